//--- common/trellisPkg.sv
// Shared definitions for the demodulator top-level glue
// Bus and sample widths, host address map, DAC select codes
// and the DAC sample word
package trellisPkg;

  //**************************************************************************
  // Widths
  //**************************************************************************
  localparam int BUS_WIDTH    = 16;     // Host data bus
  localparam int ADDR_WIDTH   = 12;     // Byte address, bit 1 picks the halfword
  localparam int REG_WIDTH    = 32;
  localparam int SAMPLE_WIDTH = 18;     // Demod and trellis sample streams
  localparam int DAC_WIDTH    = 14;
  localparam int NUM_DACS     = 3;
  localparam int SEL_WIDTH    = 4;

  //**************************************************************************
  // Address map
  //**************************************************************************
  // Space codes sit in address bits 11..8
  localparam logic [3:0] SPACE_MISC = 4'hF;
  localparam logic [3:0] SPACE_DAC  = 4'hE;

  // Misc register offsets
  localparam logic [7:0] MISC_VERSION = 8'h00;
  localparam logic [7:0] MISC_CLOCK   = 8'h04;
  localparam logic [7:0] MISC_RESET   = 8'h08;

  // DAC select register n lives at base + stride*n
  localparam logic [7:0] DAC_SEL_BASE   = 8'h00;
  localparam int         DAC_SEL_STRIDE = 4;

  localparam logic [15:0] VER_NUMBER = 16'h007D;

  // Select codes that route the trellis stream to a DAC
  localparam logic [SEL_WIDTH-1:0] SEL_TRELLIS_I     = 4'h8;
  localparam logic [SEL_WIDTH-1:0] SEL_TRELLIS_Q     = 4'h9;
  localparam logic [SEL_WIDTH-1:0] SEL_TRELLIS_PHERR = 4'hA;
  localparam logic [SEL_WIDTH-1:0] SEL_TRELLIS_INDEX = 4'hB;

  localparam int RESET_STRETCH = 5;     // Software reset length in cycles

  //**************************************************************************
  // DAC sample word
  //**************************************************************************
  // Same 18 bits seen as a two's complement sample or split for the DAC
  typedef union packed {
    logic signed [SAMPLE_WIDTH-1:0] sample;
    struct packed {
      logic                               sign;
      logic [DAC_WIDTH-2:0]               mag;   // Bits 16..4
      logic [SAMPLE_WIDTH-DAC_WIDTH-1:0]  low;   // Dropped below the DAC LSB
    } fields;
  } dacSample_u;

endpackage

//--- logic/hostBusPort.sv
// Host register port
// Decodes the address space into write strobes for the misc and DAC
// blocks, and returns the selected halfword of their read words one
// cycle after the read

`timescale 1ns/100ps

module hostBusPort (
  input  logic                             ck933,
  input  logic                             clockCounterEn,
  input  logic                             busCs_i,
  input  logic                             busWe_i,
  input  logic                             busRd_i,
  input  logic [trellisPkg::ADDR_WIDTH-1:0] busAddr_i,
  input  logic [trellisPkg::BUS_WIDTH-1:0]  busWrData_i,
  input  logic [trellisPkg::REG_WIDTH-1:0]  miscRdWord_i,
  input  logic [trellisPkg::REG_WIDTH-1:0]  dacRdWord_i,
  output logic                             miscWr_o,
  output logic                             dacWr_o,
  output logic [7:0]                       regOffset_o,
  output logic                             halfHigh_o,
  output logic [trellisPkg::BUS_WIDTH-1:0]  wrData_o,
  output logic [trellisPkg::BUS_WIDTH-1:0]  busRdData_o
);

  import trellisPkg::*;

  logic [3:0]           space;
  logic                 wrCycle;
  logic                 rdCycle;
  logic [REG_WIDTH-1:0] rdWord;
  logic [BUS_WIDTH-1:0] rdHalf;

  //**************************************************************************
  // Address decode
  //**************************************************************************
  assign space   = busAddr_i[ADDR_WIDTH-1:ADDR_WIDTH-4];
  assign wrCycle = busCs_i & busWe_i;
  assign rdCycle = busCs_i & busRd_i;

  // Blocks see the byte offset, so bit 1 still tells the halves apart
  assign regOffset_o = busAddr_i[7:0];
  assign halfHigh_o  = busAddr_i[1];
  assign wrData_o    = busWrData_i;

  assign miscWr_o = wrCycle && (space == SPACE_MISC);
  assign dacWr_o  = wrCycle && (space == SPACE_DAC);

  //**************************************************************************
  // Read data
  //**************************************************************************
  always_comb begin
    case (space)
      SPACE_MISC: rdWord = miscRdWord_i;
      SPACE_DAC:  rdWord = dacRdWord_i;
      default:    rdWord = '0;            // Unmapped space
    endcase
  end

  assign rdHalf = halfHigh_o ? rdWord[REG_WIDTH-1:BUS_WIDTH] : rdWord[BUS_WIDTH-1:0];

  // Loaded on the read cycle only, held until the next read
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      busRdData_o <= '0;
    end else if (rdCycle) begin
      busRdData_o <= rdHalf;
    end
  end

endmodule

//--- misc/miscRegs.sv
// Miscellaneous register block
// Version word, free-running clock counter with start and capture,
// and the software reset stretched out to the DAC reset pin

`timescale 1ns/100ps

module miscRegs (
  input  logic                            ck933,
  input  logic                            clockCounterEn,
  input  logic                            miscWr_i,
  input  logic [7:0]                      regOffset_i,
  input  logic                            halfHigh_i,
  input  logic [trellisPkg::BUS_WIDTH-1:0] wrData_i,
  output logic [trellisPkg::REG_WIDTH-1:0] miscRdWord_o,
  output logic                            softReset_o
);

  import trellisPkg::*;

  logic [7:0]                         wordOffset;
  logic                               clockWr;
  logic                               resetWr;
  logic [REG_WIDTH-1:0]               clockCounter;
  logic [REG_WIDTH-1:0]               clockHold;
  logic [$clog2(RESET_STRETCH)-1:0]   resetCount;

  assign wordOffset = {regOffset_i[7:2], 2'b00};

  // Counter control comes from the low halfword, data bit 0
  assign clockWr = miscWr_i && !halfHigh_i && (wordOffset == MISC_CLOCK);
  assign resetWr = miscWr_i && (wordOffset == MISC_RESET);

  //**************************************************************************
  // Clock counter
  //**************************************************************************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      clockCounter <= '0;
      clockHold    <= '0;
    end else begin
      if (clockWr && wrData_i[0]) begin
        clockCounter <= '0;                 // Start
      end else begin
        clockCounter <= clockCounter + 1'b1;
      end
      // Capture the count as it lands at this edge, so hold = edges since start
      if (clockWr && !wrData_i[0]) begin
        clockHold <= clockCounter + 1'b1;
      end
    end
  end

  //**************************************************************************
  // Software reset stretcher
  //**************************************************************************
  // Output rises on the write edge and stays up for RESET_STRETCH cycles
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      resetCount  <= '0;
      softReset_o <= 1'b0;
    end else if (resetWr) begin
      resetCount  <= $bits(resetCount)'(RESET_STRETCH - 1);
      softReset_o <= 1'b1;
    end else if (resetCount != 0) begin
      resetCount <= resetCount - 1'b1;
    end else begin
      softReset_o <= 1'b0;
    end
  end

  // Read word for the current offset
  always_comb begin
    case (wordOffset)
      MISC_VERSION: miscRdWord_o = {VER_NUMBER, 16'h0000};
      MISC_CLOCK:   miscRdWord_o = clockHold;
      default:      miscRdWord_o = '0;      // Reset register reads back zero
    endcase
  end

endmodule

//--- dac/dacOutputSelect.sv
// DAC output stage
// Per-channel select registers pick the trellis or the legacy demod
// stream; the chosen sample is loaded into the DAC word on its sync
// with the sign bit flipped for offset binary

`timescale 1ns/100ps

module dacOutputSelect (
  input  logic                               ck933,
  input  logic                               clockCounterEn,
  input  logic                               softReset_i,
  input  logic                               dacWr_i,
  input  logic [7:0]                         regOffset_i,
  input  logic [trellisPkg::BUS_WIDTH-1:0]    wrData_i,
  input  logic [trellisPkg::SAMPLE_WIDTH-1:0] demodSample_i [trellisPkg::NUM_DACS],
  input  logic [trellisPkg::NUM_DACS-1:0]     demodSync_i,
  input  logic [trellisPkg::SAMPLE_WIDTH-1:0] trellisSample_i [trellisPkg::NUM_DACS],
  input  logic [trellisPkg::NUM_DACS-1:0]     trellisSync_i,
  output logic [trellisPkg::REG_WIDTH-1:0]    dacRdWord_o,
  output logic [trellisPkg::DAC_WIDTH-1:0]    dacData_o [trellisPkg::NUM_DACS]
);

  import trellisPkg::*;

  logic [SEL_WIDTH-1:0] dacSel [NUM_DACS];
  logic [NUM_DACS-1:0]  selWr;
  logic [NUM_DACS-1:0]  selRd;
  logic [NUM_DACS-1:0]  useTrellis;
  dacSample_u           muxSample [NUM_DACS];
  logic [NUM_DACS-1:0]  muxSync;

  // Codes 8..B belong to the trellis decoder
  function automatic logic isTrellis(input logic [SEL_WIDTH-1:0] code);
    case (code)
      SEL_TRELLIS_I,
      SEL_TRELLIS_Q,
      SEL_TRELLIS_PHERR,
      SEL_TRELLIS_INDEX: isTrellis = 1'b1;
      default:           isTrellis = 1'b0;
    endcase
  endfunction

  //**************************************************************************
  // Select registers
  //**************************************************************************
  always_comb begin
    for (int n = 0; n < NUM_DACS; n++) begin
      // Exact byte offset match, so only the low halfword writes
      selWr[n] = dacWr_i && (regOffset_i == 8'(DAC_SEL_BASE + n * DAC_SEL_STRIDE));
      selRd[n] = ({regOffset_i[7:2], 2'b00} == 8'(DAC_SEL_BASE + n * DAC_SEL_STRIDE));
      useTrellis[n] = isTrellis(dacSel[n]);
    end
  end

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      for (int n = 0; n < NUM_DACS; n++) begin
        dacSel[n] <= '0;
      end
    end else begin
      for (int n = 0; n < NUM_DACS; n++) begin
        if (softReset_i) begin
          dacSel[n] <= '0;
        end else if (selWr[n]) begin
          dacSel[n] <= wrData_i[SEL_WIDTH-1:0];
        end
      end
    end
  end

  // Zero-extended readback, high half always zero
  always_comb begin
    dacRdWord_o = '0;
    for (int n = 0; n < NUM_DACS; n++) begin
      if (selRd[n]) begin
        dacRdWord_o = {{(REG_WIDTH - SEL_WIDTH){1'b0}}, dacSel[n]};
      end
    end
  end

  //**************************************************************************
  // Source mux and DAC output registers
  //**************************************************************************
  always_ff @(posedge ck933) begin
    for (int n = 0; n < NUM_DACS; n++) begin
      muxSample[n].sample <= useTrellis[n] ? $signed(trellisSample_i[n])
                                           : $signed(demodSample_i[n]);
    end
  end

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      muxSync <= '0;
      for (int n = 0; n < NUM_DACS; n++) begin
        dacData_o[n] <= '0;
      end
    end else begin
      for (int n = 0; n < NUM_DACS; n++) begin
        if (softReset_i) begin
          muxSync[n]   <= 1'b0;
          dacData_o[n] <= '0;
        end else begin
          muxSync[n] <= useTrellis[n] ? trellisSync_i[n] : demodSync_i[n];
          // Offset binary: flip the sign, keep bits 16..4
          if (muxSync[n]) begin
            dacData_o[n] <= {~muxSample[n].fields.sign, muxSample[n].fields.mag};
          end
        end
      end
    end
  end

endmodule

//--- logic/trellisTop.sv
// Demodulator top-level glue
// Host register port, misc register block and the DAC output stage

`timescale 1ns/100ps

module trellisTop (
  input  logic                               ck933,
  input  logic                               clockCounterEn,
  input  logic                               busCs_i,
  input  logic                               busWe_i,
  input  logic                               busRd_i,
  input  logic [trellisPkg::ADDR_WIDTH-1:0]   busAddr_i,
  input  logic [trellisPkg::BUS_WIDTH-1:0]    busWrData_i,
  input  logic [trellisPkg::SAMPLE_WIDTH-1:0] demodSample_i [trellisPkg::NUM_DACS],
  input  logic [trellisPkg::NUM_DACS-1:0]     demodSync_i,
  input  logic [trellisPkg::SAMPLE_WIDTH-1:0] trellisSample_i [trellisPkg::NUM_DACS],
  input  logic [trellisPkg::NUM_DACS-1:0]     trellisSync_i,
  output logic [trellisPkg::BUS_WIDTH-1:0]    busRdData_o,
  output logic [trellisPkg::DAC_WIDTH-1:0]    dacData_o [trellisPkg::NUM_DACS],
  output logic                               dacRst_o
);

  import trellisPkg::*;

  logic                 miscWr;
  logic                 dacWr;
  logic [7:0]           regOffset;
  logic                 halfHigh;
  logic [BUS_WIDTH-1:0] wrData;
  logic [REG_WIDTH-1:0] miscRdWord;
  logic [REG_WIDTH-1:0] dacRdWord;
  logic                 softReset;

  assign dacRst_o = softReset;          // Also clears the DAC stage

  hostBusPort uHostBusPort (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .busCs_i        (busCs_i),
    .busWe_i        (busWe_i),
    .busRd_i        (busRd_i),
    .busAddr_i      (busAddr_i),
    .busWrData_i    (busWrData_i),
    .miscRdWord_i   (miscRdWord),
    .dacRdWord_i    (dacRdWord),
    .miscWr_o       (miscWr),
    .dacWr_o        (dacWr),
    .regOffset_o    (regOffset),
    .halfHigh_o     (halfHigh),
    .wrData_o       (wrData),
    .busRdData_o    (busRdData_o)
  );

  miscRegs uMiscRegs (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .miscWr_i       (miscWr),
    .regOffset_i    (regOffset),
    .halfHigh_i     (halfHigh),
    .wrData_i       (wrData),
    .miscRdWord_o   (miscRdWord),
    .softReset_o    (softReset)
  );

  dacOutputSelect uDacOutputSelect (
    .ck933           (ck933),
    .clockCounterEn  (clockCounterEn),
    .softReset_i     (softReset),
    .dacWr_i         (dacWr),
    .regOffset_i     (regOffset),
    .wrData_i        (wrData),
    .demodSample_i   (demodSample_i),
    .demodSync_i     (demodSync_i),
    .trellisSample_i (trellisSample_i),
    .trellisSync_i   (trellisSync_i),
    .dacRdWord_o     (dacRdWord),
    .dacData_o       (dacData_o)
  );

endmodule

//--- sim/trellisTop_assertions.sv
// Bound checks on the top-level bus strobes, read data and DAC reset

`timescale 1ns/100ps

module trellisTop_assertions (
  input logic                            ck933,
  input logic                            clockCounterEn,
  input logic                            busWe_i,
  input logic                            busRd_i,
  input logic [trellisPkg::BUS_WIDTH-1:0] busRdData_o,
  input logic                            dacRst_o
);

  import trellisPkg::*;

  int highCount;                              // Edges with the DAC reset seen high
  int errorCount = 0;                         // Assertion failures so far

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      highCount <= 0;
    end else if (dacRst_o) begin
      highCount <= highCount + 1;
    end else begin
      highCount <= 0;
    end
  end

  noReadWithWrite: assert property (@(posedge ck933) disable iff (clockCounterEn)
    !(busWe_i && busRd_i)) else begin
    errorCount = errorCount + 1;
    $error("bus read and write strobes high together");
  end

  resetPulseBound: assert property (@(posedge ck933) disable iff (clockCounterEn)
    dacRst_o |-> highCount < RESET_STRETCH) else begin
    errorCount = errorCount + 1;
    $error("DAC reset held too long");
  end

  readDataKnown: assert property (@(posedge ck933) disable iff (clockCounterEn)
    !$isunknown(busRdData_o)) else begin
    errorCount = errorCount + 1;
    $error("read data unknown after reset");
  end

endmodule

//--- sim/tbChecker.sv
// Result checker for the top-level glue
// Compares read data one cycle after each read, DAC words two cycles
// after each sample drive, and the width of the DAC reset pulse

`timescale 1ns/100ps

module tbChecker (
  input  logic                             ck933,
  input  logic                             clockCounterEn,
  input  logic                             busCs_i,
  input  logic                             busWe_i,
  input  logic                             busRd_i,
  input  logic [trellisPkg::ADDR_WIDTH-1:0] busAddr_i,
  input  logic [trellisPkg::BUS_WIDTH-1:0]  busRdData_i,
  input  logic [trellisPkg::DAC_WIDTH-1:0]  dacData_i [trellisPkg::NUM_DACS],
  input  logic                             dacRst_i,
  input  logic [8*20-1:0]                  testName_i,
  input  logic [trellisPkg::BUS_WIDTH-1:0]  readExp_i,
  input  logic                             driveCheck_i,
  input  logic [trellisPkg::DAC_WIDTH-1:0]  dacExp_i [trellisPkg::NUM_DACS],
  output int                               passCount_o,
  output int                               failCount_o
);

  import trellisPkg::*;

  logic                 readPending;
  logic [BUS_WIDTH-1:0] readExpQ;
  logic [8*20-1:0]      readName;
  logic [1:0]           drivePending;           // Two-stage DAC pipeline
  logic [DAC_WIDTH-1:0] expStage0 [NUM_DACS];
  logic [DAC_WIDTH-1:0] expStage1 [NUM_DACS];
  logic [8*20-1:0]      nameStage0;
  logic [8*20-1:0]      nameStage1;
  logic                 resetWrSeen;
  logic [8*20-1:0]      resetName;
  int                   resetWidth;

  task automatic compareValue(input logic [8*20-1:0] name, input string tag,
                              input logic [BUS_WIDTH-1:0] expected,
                              input logic [BUS_WIDTH-1:0] actual);
    if (actual === expected) begin
      passCount_o = passCount_o + 1;
      $display("ok       %0s%0s = %h", name, tag, actual);
    end else begin
      failCount_o = failCount_o + 1;
      $display("mismatch %0s%0s expected %h actual %h", name, tag, expected, actual);
    end
  endtask

  always @(posedge ck933) begin
    if (clockCounterEn) begin
      readPending  = 1'b0;
      drivePending = '0;
      resetWrSeen  = 1'b0;
      resetWidth   = 0;
      passCount_o  = 0;
      failCount_o  = 0;
    end else begin
      if (readPending) begin
        compareValue(readName, "", readExpQ, busRdData_i);
      end
      readPending = busCs_i & busRd_i;
      readExpQ    = readExp_i;
      readName    = testName_i;

      //**********************************************************************
      // DAC words, two edges after the sync
      //**********************************************************************
      if (drivePending[1]) begin
        for (int n = 0; n < NUM_DACS; n++) begin
          compareValue(nameStage1, $sformatf(" dac%0d", n),
                       {2'b00, expStage1[n]}, {2'b00, dacData_i[n]});
        end
      end
      drivePending[1] = drivePending[0];
      drivePending[0] = driveCheck_i;
      nameStage1      = nameStage0;
      nameStage0      = testName_i;
      for (int n = 0; n < NUM_DACS; n++) begin
        expStage1[n] = expStage0[n];
        expStage0[n] = dacExp_i[n];
      end

      // Reset pulse must rise after the write and is measured when it falls
      if (resetWrSeen && !dacRst_i) begin
        failCount_o = failCount_o + 1;
        $display("%0s: dacRst did not go high after the reset write", resetName);
      end
      if (dacRst_i) begin
        resetWidth = resetWidth + 1;
      end else if (resetWidth != 0) begin
        compareValue(resetName, " dacRst width", 16'(RESET_STRETCH), 16'(resetWidth));
        resetWidth = 0;
      end
      resetWrSeen = busCs_i & busWe_i & (busAddr_i == {SPACE_MISC, MISC_RESET});
      if (resetWrSeen) begin
        resetName = testName_i;               // Entry that wrote the reset
      end
    end
  end

endmodule

//--- sim/tbTrellisTop.sv
// Testbench for the demodulator top-level glue
// Runs a table of bus and sample operations against the DUT,
// tbChecker does the comparing

`timescale 1ns/100ps

module tbTrellisTop;

  import trellisPkg::*;

  localparam logic [1:0] OP_WRITE = 2'd0;
  localparam logic [1:0] OP_READ  = 2'd1;
  localparam logic [1:0] OP_DRIVE = 2'd2;
  localparam logic [1:0] OP_WAIT  = 2'd3;
  localparam int MAX_ENTRIES = 40;

  logic                    ck933 = 1'b0;
  logic                    clockCounterEn;
  logic                    busCs;
  logic                    busWe;
  logic                    busRd;
  logic [ADDR_WIDTH-1:0]   busAddr;
  logic [BUS_WIDTH-1:0]    busWrData;
  logic [SAMPLE_WIDTH-1:0] demodSample [NUM_DACS];
  logic [NUM_DACS-1:0]     demodSync;
  logic [SAMPLE_WIDTH-1:0] trellisSample [NUM_DACS];
  logic [NUM_DACS-1:0]     trellisSync;
  logic [BUS_WIDTH-1:0]    busRdData;
  logic [DAC_WIDTH-1:0]    dacData [NUM_DACS];
  logic                    dacRst;

  // Expected values handed to the checker with each entry
  logic [8*20-1:0]         checkName;
  logic [BUS_WIDTH-1:0]    readExp;
  logic                    driveCheck;
  logic [DAC_WIDTH-1:0]    dacExp [NUM_DACS];
  logic [DAC_WIDTH-1:0]    dacModel [NUM_DACS];   // DAC words as they should stand

  //**************************************************************************
  // Stimulus table
  //**************************************************************************
  logic [8*20-1:0]         tName [MAX_ENTRIES];
  logic [1:0]              tOp [MAX_ENTRIES];
  logic [ADDR_WIDTH-1:0]   tAddr [MAX_ENTRIES];
  logic [BUS_WIDTH-1:0]    tData [MAX_ENTRIES];   // Write data, sync mask or wait cycles
  logic [BUS_WIDTH-1:0]    tExp [MAX_ENTRIES];    // Read value or trellis channel mask
  int                      numEntries = 0;
  int                      timeoutLimit = 0;
  int                      cycles = 0;
  int                      seed = 74408;
  int                      passCount;
  int                      failCount;

  always #10 ck933 = ~ck933;

  trellisTop dut (
    .ck933           (ck933),
    .clockCounterEn  (clockCounterEn),
    .busCs_i         (busCs),
    .busWe_i         (busWe),
    .busRd_i         (busRd),
    .busAddr_i       (busAddr),
    .busWrData_i     (busWrData),
    .demodSample_i   (demodSample),
    .demodSync_i     (demodSync),
    .trellisSample_i (trellisSample),
    .trellisSync_i   (trellisSync),
    .busRdData_o     (busRdData),
    .dacData_o       (dacData),
    .dacRst_o        (dacRst)
  );

  tbChecker uChecker (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .busCs_i        (busCs),
    .busWe_i        (busWe),
    .busRd_i        (busRd),
    .busAddr_i      (busAddr),
    .busRdData_i    (busRdData),
    .dacData_i      (dacData),
    .dacRst_i       (dacRst),
    .testName_i     (checkName),
    .readExp_i      (readExp),
    .driveCheck_i   (driveCheck),
    .dacExp_i       (dacExp),
    .passCount_o    (passCount),
    .failCount_o    (failCount)
  );

  bind trellisTop trellisTop_assertions uAssertions (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .busWe_i        (busWe_i),
    .busRd_i        (busRd_i),
    .busRdData_o    (busRdData_o),
    .dacRst_o       (dacRst_o)
  );

  task automatic addEntry(input logic [8*20-1:0] name, input logic [1:0] op,
                          input logic [ADDR_WIDTH-1:0] addr, input logic [BUS_WIDTH-1:0] data,
                          input logic [BUS_WIDTH-1:0] expected);
    tName[numEntries] = name;
    tOp[numEntries]   = op;
    tAddr[numEntries] = addr;
    tData[numEntries] = data;
    tExp[numEntries]  = expected;
    numEntries = numEntries + 1;
  endtask

  // Sign bit flipped, bits 16..4 kept
  function automatic logic [DAC_WIDTH-1:0] offsetBinary(input logic [SAMPLE_WIDTH-1:0] s);
    offsetBinary = {~s[SAMPLE_WIDTH-1], s[SAMPLE_WIDTH-2:SAMPLE_WIDTH-DAC_WIDTH]};
  endfunction

  task automatic idleInputs();
    busCs       = 1'b0;
    busWe       = 1'b0;
    busRd       = 1'b0;
    demodSync   = '0;
    trellisSync = '0;
    driveCheck  = 1'b0;
  endtask

  task automatic buildTable();
    addEntry("version low",       OP_READ,  12'hF00, 16'h0000, 16'h0000);
    addEntry("version high",      OP_READ,  12'hF02, 16'h0000, 16'h007D);
    addEntry("unmapped space",    OP_READ,  12'hD02, 16'h0000, 16'h0000);
    addEntry("sel0 trellis I",    OP_WRITE, 12'hE00, 16'h0008, 16'h0000);
    addEntry("sel1 demod",        OP_WRITE, 12'hE04, 16'h0003, 16'h0000);
    addEntry("sel2 trellis index", OP_WRITE, 12'hE08, 16'h000B, 16'h0000);
    addEntry("sel1 high half",    OP_WRITE, 12'hE06, 16'h000F, 16'h0000);
    addEntry("sel0 readback",     OP_READ,  12'hE00, 16'h0000, 16'h0008);
    addEntry("sel1 readback",     OP_READ,  12'hE04, 16'h0000, 16'h0003);
    addEntry("sel2 readback",     OP_READ,  12'hE08, 16'h0000, 16'h000B);
    addEntry("sel2 high readback", OP_READ,  12'hE0A, 16'h0000, 16'h0000);
    addEntry("route all",         OP_DRIVE, 12'h000, 16'h0007, 16'h0005);
    addEntry("route all again",   OP_DRIVE, 12'h000, 16'h0007, 16'h0005);
    addEntry("hold without sync", OP_DRIVE, 12'h000, 16'h0000, 16'h0005);
    addEntry("sync dac1 only",    OP_DRIVE, 12'h000, 16'h0002, 16'h0005);
    addEntry("sel0 demod",        OP_WRITE, 12'hE00, 16'h0002, 16'h0000);
    addEntry("sel1 trellis Q",    OP_WRITE, 12'hE04, 16'h0009, 16'h0000);
    addEntry("sel2 code C",       OP_WRITE, 12'hE08, 16'h000C, 16'h0000);
    addEntry("route new selects", OP_DRIVE, 12'h000, 16'h0007, 16'h0002);
    addEntry("clock start",       OP_WRITE, 12'hF04, 16'h0001, 16'h0000);
    addEntry("clock wait",        OP_WAIT,  12'h000, 16'h0008, 16'h0000);
    addEntry("clock capture",     OP_WRITE, 12'hF04, 16'h0000, 16'h0000);
    addEntry("clock count low",   OP_READ,  12'hF04, 16'h0000, 16'h0009);
    addEntry("clock count high",  OP_READ,  12'hF06, 16'h0000, 16'h0000);
    addEntry("settle",            OP_WAIT,  12'h000, 16'h0003, 16'h0000);
    addEntry("soft reset",        OP_WRITE, 12'hF08, 16'h0001, 16'h0000);
    addEntry("reset wait",        OP_WAIT,  12'h000, 16'h0008, 16'h0000);
    addEntry("sel0 after reset",  OP_READ,  12'hE00, 16'h0000, 16'h0000);
    addEntry("sel1 after reset",  OP_READ,  12'hE04, 16'h0000, 16'h0000);
    addEntry("sel2 after reset",  OP_READ,  12'hE08, 16'h0000, 16'h0000);
    addEntry("dac zero after reset", OP_DRIVE, 12'h000, 16'h0000, 16'h0000);
    addEntry("demod after reset", OP_DRIVE, 12'h000, 16'h0007, 16'h0000);
  endtask

  // One table entry, driven 2 ns after the edge and held for one cycle
  task automatic applyEntry(input int i);
    int r;
    checkName = tName[i];
    case (tOp[i])
      OP_WRITE: begin
        busCs     = 1'b1;
        busWe     = 1'b1;
        busAddr   = tAddr[i];
        busWrData = tData[i];
        if (tAddr[i] == {SPACE_MISC, MISC_RESET}) begin
          for (int n = 0; n < NUM_DACS; n++) begin
            dacModel[n] = '0;                 // Soft reset clears the DAC words
          end
        end
      end
      OP_READ: begin
        busCs   = 1'b1;
        busRd   = 1'b1;
        busAddr = tAddr[i];
        readExp = tExp[i];
      end
      OP_DRIVE: begin
        for (int n = 0; n < NUM_DACS; n++) begin
          r = $random(seed);
          demodSample[n] = r[SAMPLE_WIDTH-1:0];
          r = $random(seed);
          trellisSample[n] = r[SAMPLE_WIDTH-1:0];
          if (tData[i][n]) begin
            dacModel[n] = tExp[i][n] ? offsetBinary(trellisSample[n])
                                     : offsetBinary(demodSample[n]);
          end
          dacExp[n] = dacModel[n];
        end
        // The other stream gets its sync only on channels that must hold
        demodSync   = tData[i][NUM_DACS-1:0] ^ tExp[i][NUM_DACS-1:0];
        trellisSync = ~demodSync;
        driveCheck  = 1'b1;
      end
      default: begin
      end
    endcase
    @(posedge ck933);
    #2;
    idleInputs();
    if (tOp[i] == OP_WAIT && tData[i] > 16'd1) begin
      repeat (tData[i] - 16'd1) @(posedge ck933);
      #2;
    end
  endtask

  initial begin
    clockCounterEn = 1'b1;
    busAddr        = '0;
    busWrData      = '0;
    checkName      = '0;
    readExp        = '0;
    for (int n = 0; n < NUM_DACS; n++) begin
      demodSample[n]   = '0;
      trellisSample[n] = '0;
      dacExp[n]        = '0;
      dacModel[n]      = '0;
    end
    idleInputs();
    buildTable();
    timeoutLimit = numEntries * 4 + 50;
    repeat (5) @(posedge ck933);
    #2;
    clockCounterEn = 1'b0;
    for (int i = 0; i < numEntries; i++) begin
      applyEntry(i);
    end
    repeat (4) @(posedge ck933);      // Let the last checks land
    #2;
    $display("tests: %0d passed, %0d failed, %0d assertion errors",
             passCount, failCount, dut.uAssertions.errorCount);
    if (failCount == 0 && passCount > 0 && dut.uAssertions.errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Run limit from the table length
  always @(posedge ck933) begin
    cycles = cycles + 1;
    if (timeoutLimit > 0 && cycles >= timeoutLimit) begin
      $display("timeout: the table did not finish within %0d cycles", timeoutLimit);
      $display("=== FAIL ===");
      $finish;
    end
  end

endmodule

//--- verilog.f
common/trellisPkg.sv
logic/hostBusPort.sv
misc/miscRegs.sv
dac/dacOutputSelect.sv
logic/trellisTop.sv
sim/trellisTop_assertions.sv
sim/tbChecker.sv
sim/tbTrellisTop.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tbTrellisTop -f verilog.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/VtbTrellisTop > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
  echo "no result line found in $LOG"
  exit 1
fi
exit 0
